// File: uclk_ctrl_macros.svh
/*
 * Shared constants for the user clock control block.
 * Include in any file that needs them; guarded against double inclusion.
 */

`ifndef UCLK_CTRL_MACROS_SVH
`define UCLK_CTRL_MACROS_SVH

// Feature version reported in status word 1, software keys off this
`define UCLK_VER 4'h4

// Reference clock in 10 kHz units, 10000 means 100 MHz
`define UCLK_REF 18'd10000

// Frequency window length in clk cycles
`define UCLK_FREQ_WINDOW 256

// PLL model latencies
`define UCLK_WAIT_CYCLES 2   // Waitrequest cycles per request
`define UCLK_LOCK_CYCLES 16  // Reset release or divider write to lock

// Divider register in the PLL model
`define UCLK_DIV_ADDR 10'd0

`endif

// File: uclk_csr_pkg.sv
/*
 * Layout of the software command and status words.
 * Referenced by scoped name from the top and the testbench.
 */

package uclk_csr_pkg;

   // Reconfig request as kept in the readback latch, 45 bits
   typedef struct packed {
      logic [1:0]  seq;    // Sequence number, change starts a request
      logic        write;  // 1 write, 0 read
      logic [9:0]  addr;   // Management address
      logic [31:0] data;   // Write data or readback
   } t_rcfg_ctrl;

   // Command word 0, raw or by field
   typedef union packed {
      logic [63:0] raw;
      struct packed {
         logic [5:0]  rsvd_63_58;
         logic        pll_reset;    // 57
         logic        mgmt_reset;   // 56
         logic [2:0]  rsvd_55_53;
         logic        fsm_reset_n;  // 52, active low
         logic [1:0]  rsvd_51_50;
         logic [1:0]  seq;          // 49:48
         logic [2:0]  rsvd_47_45;
         logic        write;        // 44
         logic [1:0]  rsvd_43_42;
         logic [9:0]  addr;         // 41:32
         logic [31:0] data;         // 31:0, only low byte reaches the PLL
      } f;
   } t_cmd0;

endpackage

// File: uclk_rcfg_pkg.sv
/*
 * Reconfiguration FSM states and management port widths.
 */

package uclk_rcfg_pkg;

   // Management port of the PLL
   localparam int MGMT_ADDR_W = 10;
   localparam int MGMT_DATA_W = 8;

   typedef enum logic [1:0] {
      IDLE   = 2'd0,  // Waiting for a seq change
      REQ    = 2'd1,  // First strobe cycle
      RDWAIT = 2'd2,  // Strobe held through waitrequest
      LATCH  = 2'd3   // Readback latch pulse
   } t_rcfg_state;

endpackage

// File: uclk_rcfg_fsm.sv
/*
 * Reconfiguration FSM. A change of the sequence number runs one read or
 * write on the PLL management port, then pulses the readback latch.
 */

`timescale 1ns/1ns

module uclk_rcfg_fsm (
   input  logic       clk,
   input  logic       fsm_reset_n,        // Sync, active low
   input  logic [1:0] rcfg_seq,
   input  logic       rcfg_write,         // 1 write, 0 read
   input  logic       mgmt_waitrequest,
   output logic       mgmt_read,
   output logic       mgmt_write,
   output logic       enable_read_latch,  // One cycle after completion
   output logic       error               // Sticky until fsm_reset_n low
);

   uclk_rcfg_pkg::t_rcfg_state state;
   logic [1:0]                 last_seq;   // Seq of last accepted request
   logic                       seq_new;
   logic                       busy;

   assign seq_new = (rcfg_seq != last_seq);
   assign busy    = (state != uclk_rcfg_pkg::IDLE);

   assign enable_read_latch = (state == uclk_rcfg_pkg::LATCH);

   // --------------------
   // State and strobes
   // --------------------
   always_ff @(posedge clk) begin
      if (!fsm_reset_n) begin
         state      <= uclk_rcfg_pkg::IDLE;
         last_seq   <= rcfg_seq;  // No request fires on reset release
         mgmt_read  <= 1'b0;
         mgmt_write <= 1'b0;
      end else begin
         case (state)
            uclk_rcfg_pkg::IDLE: begin
               if (seq_new) begin
                  state      <= uclk_rcfg_pkg::REQ;
                  mgmt_read  <= ~rcfg_write;
                  mgmt_write <= rcfg_write;
                  last_seq   <= rcfg_seq;
               end
            end
            uclk_rcfg_pkg::REQ,
            uclk_rcfg_pkg::RDWAIT: begin
               // Strobe held until waitrequest drops
               if (!mgmt_waitrequest) begin
                  state      <= uclk_rcfg_pkg::LATCH;
                  mgmt_read  <= 1'b0;
                  mgmt_write <= 1'b0;
               end else begin
                  state <= uclk_rcfg_pkg::RDWAIT;
               end
            end
            uclk_rcfg_pkg::LATCH: begin
               state <= uclk_rcfg_pkg::IDLE;
            end
            default: begin
               state <= uclk_rcfg_pkg::IDLE;
            end
         endcase

         // Seq change in flight is dropped, never replayed later
         if (busy && seq_new) begin
            last_seq <= rcfg_seq;
         end
      end
   end

   // --------------------
   // Error flag
   // --------------------
   always_ff @(posedge clk) begin
      if (!fsm_reset_n) begin
         error <= 1'b0;
      end else if (busy && seq_new) begin
         error <= 1'b1;  // Software did not wait for status
      end
   end

endmodule

// File: uclk_pll_model.sv
/*
 * Synthesizable PLL stand-in: byte register file on a management port with
 * fixed waitrequest, a lock counter and a divider making uclk from clk.
 */

`timescale 1ns/1ns

`include "uclk_ctrl_macros.svh"

module uclk_pll_model (
   input  logic                                  clk,
   input  logic                                  reset,       // Active high
   input  logic                                  mgmt_reset,  // Timer only
   input  logic                                  mgmt_read,
   input  logic                                  mgmt_write,
   input  logic [uclk_rcfg_pkg::MGMT_ADDR_W-1:0] mgmt_address,
   input  logic [uclk_rcfg_pkg::MGMT_DATA_W-1:0] mgmt_writedata,
   output logic                                  mgmt_waitrequest,
   output logic [uclk_rcfg_pkg::MGMT_DATA_W-1:0] mgmt_readdata,
   output logic                                  locked,
   output logic                                  uclk,
   output logic                                  uclk_div2
);

   localparam int WAIT_W = $clog2(`UCLK_WAIT_CYCLES + 1);
   localparam int LOCK_W = $clog2(`UCLK_LOCK_CYCLES + 1);
   localparam int DW     = uclk_rcfg_pkg::MGMT_DATA_W;

   logic [DW-1:0]     regs [4];   // Register 0 is the divider
   logic [WAIT_W-1:0] wait_cnt;
   logic [LOCK_W-1:0] lock_cnt;
   logic [DW-1:0]     div;
   logic [DW-1:0]     div_cnt;
   logic              req;
   logic              xfer_done;  // Strobe high, waitrequest low
   logic              addr_hit;
   logic              div_write;

   assign req              = mgmt_read | mgmt_write;
   assign mgmt_waitrequest = req & (wait_cnt < WAIT_W'(`UCLK_WAIT_CYCLES));
   assign xfer_done        = req & ~mgmt_waitrequest;
   assign addr_hit         = (mgmt_address < uclk_rcfg_pkg::MGMT_ADDR_W'(4));
   assign div_write        = mgmt_write & xfer_done & (mgmt_address == `UCLK_DIV_ADDR);

   // Unmapped addresses read 0
   assign mgmt_readdata = addr_hit ? regs[mgmt_address[1:0]] : '0;

   // --------------------
   // Management port
   // --------------------
   always_ff @(posedge clk) begin
      if (reset || mgmt_reset || xfer_done) begin
         wait_cnt <= '0;
      end else if (mgmt_waitrequest) begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         regs[0] <= DW'(2);
         regs[1] <= DW'(1);
         regs[2] <= DW'(1);
         regs[3] <= DW'(1);
      end else if (mgmt_write && xfer_done && addr_hit) begin
         regs[mgmt_address[1:0]] <= mgmt_writedata;
      end
   end

   // --------------------
   // Lock and clocks
   // --------------------
   always_ff @(posedge clk) begin
      if (reset || div_write) begin
         lock_cnt <= '0;  // Relock after divider change
      end else if (!locked) begin
         lock_cnt <= lock_cnt + 1'b1;
      end
   end

   assign locked = (lock_cnt == LOCK_W'(`UCLK_LOCK_CYCLES));

   assign div = (regs[0] == '0) ? DW'(1) : regs[0];  // Zero acts as one

   always_ff @(posedge clk) begin
      if (reset || !locked) begin
         div_cnt   <= '0;
         uclk      <= 1'b0;
         uclk_div2 <= 1'b0;
      end else if (div_cnt >= div - 1'b1) begin
         div_cnt <= '0;
         uclk    <= ~uclk;
         if (!uclk) begin
            uclk_div2 <= ~uclk_div2;  // On uclk rising edge
         end
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

// File: uclk_freq_counter.sv
/*
 * Frequency counter. Counts rising edges of uclk or uclk_div2 over a fixed
 * window of clk cycles and reports the count with a one-cycle valid pulse.
 */

`timescale 1ns/1ns

`include "uclk_ctrl_macros.svh"

module uclk_freq_counter (
   input  logic        clk,
   input  logic        reset_n,     // Sync, active low
   input  logic        uclk,
   input  logic        uclk_div2,
   input  logic        sel_uclk,    // 1 uclk, 0 uclk_div2
   output logic        freq_valid,  // End of window
   output logic [16:0] freq         // Edges seen in last window
);

   localparam int WIN   = `UCLK_FREQ_WINDOW;
   localparam int WIN_W = $clog2(WIN);

   logic [WIN_W-1:0] win_cnt;
   logic             win_end;
   logic             clk_sel;
   logic             clk_sel_q;
   logic             rise;
   logic [16:0]      edge_cnt;

   assign clk_sel = sel_uclk ? uclk : uclk_div2;
   assign rise    = clk_sel & ~clk_sel_q;
   assign win_end = (win_cnt == WIN_W'(WIN - 1));

   // --------------------
   // Window timer
   // --------------------
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         win_cnt <= '0;
      end else if (win_end) begin
         win_cnt <= '0;
      end else begin
         win_cnt <= win_cnt + 1'b1;
      end
   end

   // --------------------
   // Edge count
   // --------------------
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         clk_sel_q  <= 1'b0;
         edge_cnt   <= '0;
         freq_valid <= 1'b0;
      end else begin
         clk_sel_q  <= clk_sel;
         freq_valid <= win_end;
         if (win_end) begin
            edge_cnt <= '0;  // Restart for next window
         end else if (rise) begin
            edge_cnt <= edge_cnt + 1'b1;
         end
      end
   end

   // Last cycle's edge still belongs to this window
   always_ff @(posedge clk) begin
      if (win_end) begin
         freq <= edge_cnt + 17'(rise);
      end
   end

endmodule

// File: uclk_ctrl.sv
/*
 * User clock control top. Registers the software command words, drives the
 * reconfig FSM and the PLL model, and assembles both status words.
 */

`timescale 1ns/1ns

`include "uclk_ctrl_macros.svh"

module uclk_ctrl (
   input  logic        clk,
   input  logic        uclk_reset_n,          // Sync, active low
   input  logic [63:0] user_clk_freq_cmd_0,   // Reset bits and reconfig request
   input  logic [63:0] user_clk_freq_cmd_1,   // Bit 32 picks measured clock
   output logic [63:0] user_clk_freq_sts_0,
   output logic [63:0] user_clk_freq_sts_1,
   output logic        uclk,
   output logic        uclk_div2
);

   uclk_csr_pkg::t_cmd0 cmd0;

   // Command pipeline, first stage
   logic                                   pll_reset_pre;
   logic                                   mgmt_reset_pre;
   logic                                   fsm_reset_n_pre;
   logic [1:0]                             seq_pre;
   logic                                   write_pre;
   logic [uclk_rcfg_pkg::MGMT_ADDR_W-1:0]  addr_pre;
   logic [uclk_rcfg_pkg::MGMT_DATA_W-1:0]  wdata_pre;

   // Command pipeline, second stage
   logic                                   pll_reset;
   logic                                   mgmt_reset;
   logic                                   fsm_reset_n;
   logic [1:0]                             rcfg_seq;
   logic                                   rcfg_write;
   logic [uclk_rcfg_pkg::MGMT_ADDR_W-1:0]  mgmt_address;
   logic [uclk_rcfg_pkg::MGMT_DATA_W-1:0]  mgmt_writedata;

   // Management port
   logic                                   mgmt_read;
   logic                                   mgmt_write;
   logic                                   mgmt_waitrequest;
   logic [uclk_rcfg_pkg::MGMT_DATA_W-1:0]  mgmt_readdata;
   logic [uclk_rcfg_pkg::MGMT_DATA_W-1:0]  readdata_t1;  // One cycle late

   logic                                   enable_read_latch;
   logic                                   rcfg_error;
   logic                                   pll_locked;
   logic [31:0]                            readback;
   uclk_csr_pkg::t_rcfg_ctrl               rcfg_latched;

   // Frequency path
   logic                                   sel_uclk;
   logic                                   sel_uclk_q;
   logic                                   freq_valid;
   logic [16:0]                            freq;
   logic [16:0]                            freq_q;

   assign cmd0.raw = user_clk_freq_cmd_0;

   // --------------------
   // Command pipeline
   // --------------------
   always_ff @(posedge clk) begin
      if (!uclk_reset_n) begin
         pll_reset_pre   <= 1'b0;
         mgmt_reset_pre  <= 1'b0;
         fsm_reset_n_pre <= 1'b0;  // FSM held in reset too
         seq_pre         <= '0;
         write_pre       <= 1'b0;
         addr_pre        <= '0;
         wdata_pre       <= '0;
         pll_reset       <= 1'b0;
         mgmt_reset      <= 1'b0;
         fsm_reset_n     <= 1'b0;
         rcfg_seq        <= '0;
         rcfg_write      <= 1'b0;
         mgmt_address    <= '0;
         mgmt_writedata  <= '0;
      end else begin
         pll_reset_pre   <= cmd0.f.pll_reset;
         mgmt_reset_pre  <= cmd0.f.mgmt_reset;
         fsm_reset_n_pre <= cmd0.f.fsm_reset_n;
         seq_pre         <= cmd0.f.seq;
         write_pre       <= cmd0.f.write;
         addr_pre        <= cmd0.f.addr;
         wdata_pre       <= cmd0.f.data[uclk_rcfg_pkg::MGMT_DATA_W-1:0];
         pll_reset       <= pll_reset_pre;
         mgmt_reset      <= mgmt_reset_pre;
         fsm_reset_n     <= fsm_reset_n_pre;
         rcfg_seq        <= seq_pre;
         rcfg_write      <= write_pre;
         mgmt_address    <= addr_pre;
         mgmt_writedata  <= wdata_pre;
      end
   end

   // --------------------
   // Readback latch
   // --------------------
   always_ff @(posedge clk) begin
      readdata_t1 <= mgmt_readdata;
   end

   // Writes read back as all ones in the low byte
   assign readback = {24'h0, readdata_t1 | {8{rcfg_write}}};

   always_ff @(posedge clk) begin
      if (!uclk_reset_n) begin
         rcfg_latched <= '0;
      end else if (enable_read_latch) begin
         rcfg_latched <= {rcfg_seq, rcfg_write, mgmt_address, readback};
      end
   end

   // --------------------
   // Status words
   // --------------------
   always_ff @(posedge clk) begin
      user_clk_freq_sts_0 <= {rcfg_error, 2'b0, pll_locked, 2'b0,  // 63, 60
                              pll_reset, mgmt_reset, 3'b0,         // 57, 56
                              fsm_reset_n, 2'b0,                   // 52
                              rcfg_latched.seq, 3'b0,              // 49:48
                              rcfg_latched.write, 2'b0,            // 44
                              rcfg_latched.addr,                   // 41:32
                              rcfg_latched.data};                  // 31:0
   end

   assign sel_uclk = user_clk_freq_cmd_1[32];

   always_ff @(posedge clk) begin
      sel_uclk_q <= sel_uclk;  // Echo only
   end

   always_ff @(posedge clk) begin
      if (!uclk_reset_n) begin
         freq_q <= '0;
      end else if (freq_valid) begin
         freq_q <= freq;  // Hold last full window
      end
   end

   assign user_clk_freq_sts_1 = {`UCLK_VER, 9'b0, `UCLK_REF, sel_uclk_q, 15'b0, freq_q};

   // --------------------
   // Instances
   // --------------------
   uclk_rcfg_fsm u_rcfg_fsm (
      .clk               (clk),
      .fsm_reset_n       (fsm_reset_n),
      .rcfg_seq          (rcfg_seq),
      .rcfg_write        (rcfg_write),
      .mgmt_waitrequest  (mgmt_waitrequest),
      .mgmt_read         (mgmt_read),
      .mgmt_write        (mgmt_write),
      .enable_read_latch (enable_read_latch),
      .error             (rcfg_error)
   );

   uclk_pll_model u_pll_model (
      .clk              (clk),
      .reset            (~uclk_reset_n | pll_reset),
      .mgmt_reset       (mgmt_reset),
      .mgmt_read        (mgmt_read),
      .mgmt_write       (mgmt_write),
      .mgmt_address     (mgmt_address),
      .mgmt_writedata   (mgmt_writedata),
      .mgmt_waitrequest (mgmt_waitrequest),
      .mgmt_readdata    (mgmt_readdata),
      .locked           (pll_locked),
      .uclk             (uclk),
      .uclk_div2        (uclk_div2)
   );

   uclk_freq_counter u_freq_counter (
      .clk        (clk),
      .reset_n    (uclk_reset_n),
      .uclk       (uclk),
      .uclk_div2  (uclk_div2),
      .sel_uclk   (sel_uclk),
      .freq_valid (freq_valid),
      .freq       (freq)
   );

endmodule

// File: uclk_ctrl_checker.sv
/*
 * Concurrent assertions on the management port and the readback latch of
 * the user clock control top. Bound into uclk_ctrl by the testbench.
 */

`timescale 1ns/1ns

module uclk_ctrl_checker (
   input logic                     clk,
   input logic                     uclk_reset_n,
   input logic                     fsm_reset_n,
   input logic                     mgmt_read,
   input logic                     mgmt_write,
   input logic                     mgmt_waitrequest,
   input logic                     enable_read_latch,
   input uclk_csr_pkg::t_rcfg_ctrl rcfg_latched
);

   int unsigned fail_cnt = 0;  // Failed assertions so far
   logic        req;

   assign req = mgmt_read | mgmt_write;

   // --------------------
   // Management port
   // --------------------
   a_one_strobe: assert property (@(posedge clk) disable iff (!fsm_reset_n)
      !(mgmt_read && mgmt_write))
   else begin
      fail_cnt++;
      $error("mgmt_read and mgmt_write high together");
   end

   // Strobe held through waitrequest
   a_strobe_held: assert property (@(posedge clk) disable iff (!fsm_reset_n)
      (req && mgmt_waitrequest) |=> $stable({mgmt_read, mgmt_write}))
   else begin
      fail_cnt++;
      $error("strobe changed while mgmt_waitrequest was high");
   end

   a_latch_after_xfer: assert property (@(posedge clk) disable iff (!fsm_reset_n)
      (req && !mgmt_waitrequest) |=> enable_read_latch)
   else begin
      fail_cnt++;
      $error("no enable_read_latch after a completed transfer");
   end

   // --------------------
   // Reset and latch
   // --------------------
   // Two reset cycles reach the FSM through the command pipeline
   a_quiet_in_reset: assert property (@(posedge clk)
      (!uclk_reset_n && !$past(uclk_reset_n)) |=>
         (!mgmt_read && !mgmt_write && !enable_read_latch))
   else begin
      fail_cnt++;
      $error("strobes or latch enable active during reset");
   end

   // Completed write shows all ones in the latched low byte
   a_write_readback: assert property (@(posedge clk)
      disable iff (!uclk_reset_n || !fsm_reset_n)
      (mgmt_write && !mgmt_waitrequest) |=> ##1 (rcfg_latched.data == 32'h0000_00ff))
   else begin
      fail_cnt++;
      $error("readback latch did not hold all ones after a write");
   end

endmodule

// File: tb_clk_gen.sv
/*
 * Free-running testbench clock, 4 ns period.
 * Starts low at time zero.
 */

`timescale 1ns/1ns

module tb_clk_gen (
   output logic clk
);

   localparam int HALF_NS = 2;  // Half period

   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

endmodule

// File: tb_uclk_ctrl.sv
/*
 * Testbench for the user clock control block. Drives the command words on
 * the falling clock edge and checks both status words against a reference
 * model of the PLL register file with immediate assertions.
 */

`timescale 1ns/1ns

`include "uclk_ctrl_macros.svh"

module tb_uclk_ctrl;

   localparam int W       = `UCLK_FREQ_WINDOW;
   localparam int LOCK_TO = `UCLK_LOCK_CYCLES + 20;  // Lock wait limit
   localparam int REQ_TO  = 40;                      // Request wait limit

   logic        clk;
   logic        uclk_reset_n;
   logic [63:0] cmd0_word;
   logic [63:0] cmd1_word;
   logic [63:0] sts0;
   logic [63:0] sts1;
   logic        uclk;
   logic        uclk_div2;

   logic [31:0] lfsr_state;
   logic [7:0]  ref_regs [4];  // Expected PLL registers
   logic [1:0]  cur_seq;       // Last seq sent
   int          n_checks;
   int          n_errors;
   int          test_errors;   // Errors before current test

   tb_clk_gen u_clk_gen (.clk(clk));

   uclk_ctrl uut (
      .clk                 (clk),
      .uclk_reset_n        (uclk_reset_n),
      .user_clk_freq_cmd_0 (cmd0_word),
      .user_clk_freq_cmd_1 (cmd1_word),
      .user_clk_freq_sts_0 (sts0),
      .user_clk_freq_sts_1 (sts1),
      .uclk                (uclk),
      .uclk_div2           (uclk_div2)
   );

   bind uclk_ctrl uclk_ctrl_checker u_checker (
      .clk               (clk),
      .uclk_reset_n      (uclk_reset_n),
      .fsm_reset_n       (fsm_reset_n),
      .mgmt_read         (mgmt_read),
      .mgmt_write        (mgmt_write),
      .mgmt_waitrequest  (mgmt_waitrequest),
      .enable_read_latch (enable_read_latch),
      .rcfg_latched      (rcfg_latched)
   );

   // --------------------
   // Helpers
   // --------------------
   // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};  // One step per bit
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   task automatic reset_ref_regs();
      ref_regs[0] = 8'd2;  // Divider
      ref_regs[1] = 8'd1;
      ref_regs[2] = 8'd1;
      ref_regs[3] = 8'd1;
   endtask

   task automatic check(input string name, input logic [63:0] got,
                        input logic [63:0] exp);
      n_checks++;
      assert (got === exp) else begin
         $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
         n_errors++;
      end
   endtask

   task automatic check_range(input string name, input int got, input int lo, input int hi);
      n_checks++;
      assert (got >= lo && got <= hi) else begin
         $display("error: %0t ns %s got %0d expected %0d to %0d", $time, name, got, lo, hi);
         n_errors++;
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Rising edges of uclk and uclk_div2 over n clk cycles
   task automatic count_clk_rises(input int n, output int n_uclk, output int n_div2);
      logic uclk_q;
      logic div2_q;
      n_uclk = 0;
      n_div2 = 0;
      @(negedge clk);
      uclk_q = uclk;
      div2_q = uclk_div2;
      repeat (n) begin
         @(negedge clk);
         if (uclk && !uclk_q) begin
            n_uclk++;
         end
         if (uclk_div2 && !div2_q) begin
            n_div2++;
         end
         uclk_q = uclk;
         div2_q = uclk_div2;
      end
   endtask

   // Waits up to limit cycles for a masked match on status word 0
   task automatic wait_sts0(input logic [63:0] mask, input logic [63:0] val,
                            input int limit, input string what);
      int cnt;
      cnt = 0;
      while ((sts0 & mask) !== val && cnt < limit) begin
         @(negedge clk);
         cnt++;
      end
      n_checks++;
      assert ((sts0 & mask) === val) else begin
         $display("timeout: %s not seen within %0d cycles at %0t ns", what, limit, $time);
         n_errors++;
      end
   endtask

   task automatic drive_cmd0(input logic pll_rst, input logic mgmt_rst, input logic fsm_rst_n,
                             input logic wr, input logic [9:0] addr, input logic [31:0] data);
      uclk_csr_pkg::t_cmd0 c;
      c.raw           = '0;
      c.f.pll_reset   = pll_rst;
      c.f.mgmt_reset  = mgmt_rst;
      c.f.fsm_reset_n = fsm_rst_n;
      c.f.seq         = cur_seq;
      c.f.write       = wr;
      c.f.addr        = addr;
      c.f.data        = data;
      @(negedge clk);
      cmd0_word = c.raw;
   endtask

   // One request under a new seq, then bits 49:0 of the readback
   task automatic do_request(input logic wr, input logic [9:0] addr, input logic [31:0] data);
      logic [31:0] exp_data;
      logic [63:0] exp_lo;
      cur_seq = cur_seq + 2'd1;
      drive_cmd0(1'b0, 1'b0, 1'b1, wr, addr, data);
      wait_sts0(64'h3 << 48, 64'(cur_seq) << 48, REQ_TO, "request completion");
      if (wr) begin
         exp_data = 32'h0000_00ff;  // Writes read back all ones
         if (addr < 10'd4) begin
            ref_regs[addr[1:0]] = data[7:0];
         end
      end else begin
         exp_data = (addr < 10'd4) ? {24'h0, ref_regs[addr[1:0]]} : 32'h0;
      end
      exp_lo = {14'h0, cur_seq, 3'b0, wr, 2'b0, addr, exp_data};
      check("user_clk_freq_sts_0[49:0]", {14'h0, sts0[49:0]}, exp_lo);
   endtask

   task automatic report_test(input string name);
      if (n_errors == test_errors) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, n_errors - test_errors);
      end
      test_errors = n_errors;
   endtask

   // --------------------
   // Stimulus
   // --------------------
   initial begin
      int          k;
      int          div;
      int          n_half;
      int          n_uclk;
      int          n_div2;
      logic [9:0]  addr;
      logic [31:0] data;

      uclk_reset_n = 1'b0;
      cmd0_word    = '0;
      cmd1_word    = '0;
      lfsr_state   = 32'hd21e;
      cur_seq      = '0;
      n_checks     = 0;
      n_errors     = 0;
      test_errors  = 0;
      reset_ref_regs();
      idle_cycles(8);
      uclk_reset_n = 1'b1;

      // Reset values with the FSM still held by the command word
      wait_sts0(64'h1 << 60, 64'h1 << 60, LOCK_TO, "lock after reset");
      check("user_clk_freq_sts_0", sts0, 64'h1000_0000_0000_0000);
      check("user_clk_freq_sts_1[63:60]", 64'(sts1[63:60]), 64'd4);
      check("user_clk_freq_sts_1[50:33]", 64'(sts1[50:33]), 64'd10000);
      report_test("1 reset values");

      for (k = 0; k < 8; k++) begin
         drive_cmd0(k[2], k[1], k[0], 1'b0, '0, '0);
         idle_cycles(4);  // Two pipeline stages plus status register
         check("user_clk_freq_sts_0[57]", 64'(sts0[57]), 64'(k[2]));
         check("user_clk_freq_sts_0[56]", 64'(sts0[56]), 64'(k[1]));
         check("user_clk_freq_sts_0[52]", 64'(sts0[52]), 64'(k[0]));
      end
      drive_cmd0(1'b0, 1'b0, 1'b1, 1'b0, '0, '0);
      reset_ref_regs();  // PLL reset restored defaults
      wait_sts0(64'h1 << 60, 64'h1 << 60, LOCK_TO, "lock after PLL reset");
      report_test("2 reset bit echo");

      for (k = 0; k < 6; k++) begin
         addr = 10'(rand_bits(3));
         do_request(1'b0, addr, rand_bits(32));
      end
      report_test("3 read requests");

      for (k = 0; k < 4; k++) begin
         addr = 10'(rand_bits(2));
         data = rand_bits(32);
         do_request(1'b1, addr, data);
         do_request(1'b0, addr, ~data);  // Data field ignored on reads
      end
      report_test("4 write then read");

      // Small divider keeps several edges per window
      div = 1 + int'(rand_bits(2));
      do_request(1'b1, 10'd0, 32'(div));
      wait_sts0(64'h1 << 60, 64'h1 << 60, LOCK_TO, "relock after divider write");
      n_half = W / (2 * div);
      count_clk_rises(W, n_uclk, n_div2);
      check_range("uclk rising edges", n_uclk, n_half, n_half + 1);
      check_range("uclk_div2 rising edges", n_div2, n_half / 2, (n_half + 2) / 2);
      for (k = 1; k >= 0; k--) begin
         @(negedge clk);
         cmd1_word     = '0;
         cmd1_word[32] = k[0];
         idle_cycles(2 * W + 8);  // Last full window after the switch
         check("user_clk_freq_sts_1[32]", 64'(sts1[32]), 64'(k));
         if (k == 1) begin
            check_range("user_clk_freq_sts_1[16:0]", int'(sts1[16:0]), n_half, n_half + 1);
         end else begin
            check_range("user_clk_freq_sts_1[16:0]", int'(sts1[16:0]), n_half / 2,
                        (n_half + 2) / 2);
         end
      end
      report_test("5 frequency");

      cur_seq = cur_seq + 2'd1;
      drive_cmd0(1'b0, 1'b0, 1'b1, 1'b0, 10'd1, '0);
      cur_seq = cur_seq + 2'd1;
      drive_cmd0(1'b0, 1'b0, 1'b1, 1'b0, 10'd2, '0);  // Lands while busy
      wait_sts0(64'h1 << 63, 64'h1 << 63, REQ_TO, "error after seq change in flight");
      idle_cycles(10);
      check("user_clk_freq_sts_0[63]", 64'(sts0[63]), 64'd1);  // Still set
      drive_cmd0(1'b0, 1'b0, 1'b0, 1'b0, 10'd2, '0);
      idle_cycles(2);
      drive_cmd0(1'b0, 1'b0, 1'b1, 1'b0, 10'd2, '0);
      wait_sts0(64'h1 << 63, 64'h0, REQ_TO, "error clear after FSM reset");
      check("user_clk_freq_sts_0[63]", 64'(sts0[63]), 64'd0);
      report_test("6 sticky error");

      $display("checks: %0d run, %0d failed, %0d assertion failures", n_checks, n_errors,
               uut.u_checker.fail_cnt);
      if (n_errors == 0 && uut.u_checker.fail_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: uclk_ctrl.f
+incdir+.
uclk_csr_pkg.sv
uclk_rcfg_pkg.sv
uclk_rcfg_fsm.sv
uclk_pll_model.sv
uclk_freq_counter.sv
uclk_ctrl.sv
uclk_ctrl_checker.sv
tb_clk_gen.sv
tb_uclk_ctrl.sv

// File: Makefile
# Verilator build and run for the user clock control block

VERILATOR   ?= verilator
TOP         ?= tb_uclk_ctrl
FILELIST    ?= uclk_ctrl.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing --assert
SIM_ARGS    ?= +verilator+error+limit+1000
PASS_MSG    ?= TB PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line appears in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
